//--- exec_top.f
verilog/exec_pkg.sv
verilog/exec_alu.sv
verilog/exec_branch.sv
verilog/exec_result.sv
verilog/exec_top.sv
tests/exec_tb_asserts.sv
tests/exec_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it.
# The exit status is 0 only when the testbench reports a pass.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module exec_tb \
   -f exec_top.f -o exec_sim || { echo "build failed"; exit 1; }

output="$(./obj_dir/exec_sim)"
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qx "RESULT: PASS" && exit 0 || exit 1

//--- tests/exec_tb.sv
// ==========================================================================
// Testbench for exec_top. Drives back-to-back requests, models each response
// with ref_exec and checks order, payload, latency and in_ready. Assumes the
// package default width of 16 bits.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module exec_tb;
   import exec_pkg::*;

   localparam logic [31:0] SEED = 32'hb470_39b2;
   localparam int N_ARITH = 128;
   localparam int N_SHIFT = 96;
   localparam int N_BRANCH = 96;
   localparam int N_TARGET = 64;
   localparam int N_FLOW = 96;
   localparam int TOTAL = N_ARITH + N_SHIFT + N_BRANCH + N_TARGET + N_FLOW;
   localparam int LIMIT_NS = (TOTAL + 200) * 20;

   logic clk;
   logic rst;
   logic in_valid;
   logic in_ready;
   ex_req_t in_req;
   logic out_valid;
   logic out_ready;
   ex_resp_t out_resp;

   logic [31:0] req_seed = SEED;
   logic [31:0] rdy_seed = SEED;
   int ready_mode = 0;     // 0 always ready, 1 random, 2 stall first then random
   int stall_left = 0;
   int cycle = 0;
   int passes = 0;
   int errors = 0;
   ex_resp_t exp_q[$];
   int acc_q[$];          // cycle of each input transfer so the latency can be checked

   exec_top #(.DATA_W(DATA_W_DEF)) i_exec_top (
      .clk(clk), .rst(rst), .in_valid(in_valid), .in_ready(in_ready), .in_req(in_req),
      .out_valid(out_valid), .out_ready(out_ready), .out_resp(out_resp)
   );

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // expected response worked out from the ALU and branch rules
   function automatic ex_resp_t ref_exec(input ex_req_t r);
      ex_resp_t e;
      logic [15:0] a;
      logic [15:0] b;
      int n;
      int u_sum;
      int s_sum;
      logic cond;
      a = r.inv_a ? ~r.oprnd_1 : r.oprnd_1;
      b = r.inv_b ? ~r.oprnd_2 : r.oprnd_2;
      n = b[3:0];
      u_sum = int'(a) + int'(b) + int'(r.cin);
      s_sum = int'($signed(a)) + int'($signed(b)) + int'(r.cin);
      case (r.alu_op)
         op_rol: e.alu_out = (a << n) | (a >> (16 - n));
         op_sll: e.alu_out = a << n;
         op_ror: e.alu_out = (a >> n) | (a << (16 - n));
         op_srl: e.alu_out = a >> n;
         op_add: e.alu_out = u_sum[15:0];
         op_or:  e.alu_out = a | b;
         op_xor: e.alu_out = a ^ b;
         default: e.alu_out = a & b;
      endcase
      e.zero = (e.alu_out == 16'h0000);
      if (r.alu_op != op_add) e.ofl = 1'b0;
      else if (r.sign) e.ofl = (s_sum > 32767) || (s_sum < -32768);
      else e.ofl = (u_sum > 65535);
      e.ltz = (s_sum < 0);   // true sign of the sum, so overflow cannot flip it
      e.lteq = e.ltz || e.zero;
      case (r.br_cond)
         cond_eqz: cond = (r.oprnd_1 == 16'h0000);
         cond_nez: cond = (r.oprnd_1 != 16'h0000);
         cond_ltz: cond = ($signed(r.oprnd_1) < 0);
         default:  cond = ($signed(r.oprnd_1) >= 0);
      endcase
      e.pc_src = r.jmp_instr || (r.br_instr && cond);
      e.pc_target = r.pc_inc + r.sext_imm;
      e.reg_target = r.pc_inc + r.oprnd_1;
      return e;
   endfunction

   // random request, then shaped toward what the given test needs
   function automatic ex_req_t make_req(input int kind, input int i);
      logic [95:0] bits;
      ex_req_t r;
      logic [15:0] corner [4];
      corner = '{16'h7fff, 16'h8000, 16'hffff, 16'h0000};
      for (int k = 0; k < 3; k++) begin
         req_seed = lcg_step(req_seed);
         bits[k*32 +: 32] = req_seed;
      end
      r = bits[$bits(ex_req_t)-1:0];
      case (kind)
         1: begin
            r.alu_op = op_add;
            {r.sign, r.cin, r.inv_b, r.inv_a} = i[3:0];
            if (i[4]) begin
               r.oprnd_1 = corner[i[6:5]];
               r.oprnd_2 = corner[bits[95:94]];
            end
         end
         2: begin
            r.alu_op = alu_op_e'(i % 8);
            if (i[3]) begin
               r.inv_b = 1'b0;
               r.oprnd_2[3:0] = i[4] ? 4'hf : 4'h0;
            end
         end
         3: begin
            r.br_cond = br_cond_e'(i % 4);
            case ((i / 4) % 3)
               0: r.oprnd_1 = 16'h0000;
               1: r.oprnd_1 = {1'b0, bits[94:81], 1'b1};
               default: r.oprnd_1[15] = 1'b1;
            endcase
            r.br_instr = ((i / 12) % 2) == 1;
            r.jmp_instr = ((i / 24) % 2) == 1;
         end
         4: if (i[0]) begin    // push both target adders past the top
            r.pc_inc[15:13] = 3'b111;
            r.sext_imm[15:13] = 3'b111;
            r.oprnd_1[15:13] = 3'b111;
         end
         default: ;
      endcase
      return r;
   endfunction

   task automatic check_val(input string name, input logic [31:0] want, input logic [31:0] got);
      if (want !== got) begin
         $display("Mismatch at %0t ns: %s expected %h got %h", $time, name, want, got);
         errors++;
      end else begin
         passes++;
      end
   endtask

   // holds the request until in_ready is seen, returns on the transfer edge
   task automatic drive_req(input ex_req_t r);
      bit done;
      done = 1'b0;
      in_valid <= 1'b1;
      in_req <= r;
      while (!done) begin
         @(negedge clk);
         done = in_ready;
         if (done) begin
            exp_q.push_back(ref_exec(r));
            acc_q.push_back(cycle);
         end
         @(posedge clk);
      end
   endtask

   task automatic run_test(input string name, input int kind, input int count, input int mode);
      int err_start;
      err_start = errors;
      ready_mode <= mode;
      if (mode == 2) stall_left <= 8;
      for (int i = 0; i < count; i++) drive_req(make_req(kind, i));
      in_valid <= 1'b0;
      while (exp_q.size() != 0) @(posedge clk);
      $display("test %s done: %0d packets, %0d errors", name, count, errors - err_start);
   endtask

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) cycle <= cycle + 1;

   always @(posedge clk) begin
      if (stall_left > 0) begin
         out_ready <= 1'b0;
         stall_left <= stall_left - 1;
      end else if (ready_mode == 0) begin
         out_ready <= 1'b1;
      end else begin
         rdy_seed = lcg_step(rdy_seed);
         out_ready <= (rdy_seed[31:29] != 3'b000);   // ready about 7 cycles in 8
      end
   end

   // outputs are sampled on the falling edge where nothing changes
   always @(negedge clk) begin
      ex_resp_t want;
      int acc;
      if (!rst) begin
         check_val("in_ready", !(out_valid && !out_ready), in_ready);
         if (out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
               $display("Error at %0t ns: output transfer with no packet outstanding", $time);
               errors++;
            end else begin
               want = exp_q.pop_front();
               acc = acc_q.pop_front();
               check_val("alu_out", want.alu_out, out_resp.alu_out);
               check_val("zero", want.zero, out_resp.zero);
               check_val("ofl", want.ofl, out_resp.ofl);
               check_val("ltz", want.ltz, out_resp.ltz);
               check_val("lteq", want.lteq, out_resp.lteq);
               check_val("pc_src", want.pc_src, out_resp.pc_src);
               check_val("pc_target", want.pc_target, out_resp.pc_target);
               check_val("reg_target", want.reg_target, out_resp.reg_target);
               if (ready_mode == 0) check_val("latency", acc + 1, cycle);
            end
         end
      end
   end

   initial begin
      #(LIMIT_NS);
      $display("Timeout: the DUT stopped accepting or returning packets");
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin
      rst = 1'b1;
      in_valid = 1'b0;
      in_req = '0;
      out_ready = 1'b1;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_val("out_valid", 1'b0, out_valid);
      @(posedge clk);
      run_test("arithmetic", 1, N_ARITH, 0);
      run_test("shift_logic", 2, N_SHIFT, 1);
      run_test("branch", 3, N_BRANCH, 0);
      run_test("targets", 4, N_TARGET, 1);
      run_test("flow_control", 5, N_FLOW, 2);
      errors = errors + i_exec_top.u_result.u_asserts.fail_count;
      $display("checks passed: %0d, errors: %0d", passes, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/exec_tb_asserts.sv
// ==========================================================================
// Handshake assertions for the output register, bound into exec_result.
// Failures go through $error and are also counted in fail_count.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module exec_result_asserts (
   input logic               clk,
   input logic               rst,
   input logic               in_ready,
   input logic               out_valid,
   input logic               out_ready,
   input exec_pkg::ex_resp_t out_resp
);
   int fail_count = 0;

   // the register comes out of reset empty
   a_reset_empty: assert property (@(posedge clk) rst |=> !out_valid)
      else begin
         $error("out_valid was high in the cycle after reset");
         fail_count++;
      end

   // a stalled result keeps both its valid and its payload
   a_hold_stalled: assert property (@(posedge clk) disable iff (rst)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_resp)))
      else begin
         $error("stalled result changed or vanished before it was accepted");
         fail_count++;
      end

   a_ready_when_empty: assert property (@(posedge clk) disable iff (rst)
      !out_valid |-> in_ready)
      else begin
         $error("in_ready was low while the register was empty");
         fail_count++;
      end

endmodule

bind exec_result exec_result_asserts u_asserts (
   .clk       (clk),
   .rst       (rst),
   .in_ready  (in_ready),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .out_resp  (out_resp)
);

`default_nettype wire

//--- verilog/exec_alu.sv
// ==========================================================================
// Combinational ALU. Shifts and rotates use the low log2(DATA_W) bits of
// the second operand. The ofl flag is only meaningful for add, ltz and lteq
// always come from the adder whatever the opcode is.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module exec_alu #(
   parameter int DATA_W = exec_pkg::DATA_W_DEF
) (
   input  exec_pkg::ex_req_t  req,
   output exec_pkg::alu_res_t res
);
   import exec_pkg::*;

   localparam int SH_W = $clog2(DATA_W);

   logic [DATA_W-1:0]   op_a;
   logic [DATA_W-1:0]   op_b;
   logic [SH_W-1:0]     shamt;
   logic [2*DATA_W-1:0] rot_l;
   logic [2*DATA_W-1:0] rot_r;
   logic [DATA_W:0]     add_full;
   logic [DATA_W-1:0]   sum;
   logic                cout;
   logic                sign_ofl;
   logic [DATA_W-1:0]   result;
   logic                is_zero;
   logic                is_ltz;

   assign op_a  = req.inv_a ? ~req.oprnd_1 : req.oprnd_1;
   assign op_b  = req.inv_b ? ~req.oprnd_2 : req.oprnd_2;
   assign shamt = op_b[SH_W-1:0];

   // rotating a doubled copy means the wrapped bits land in the kept half
   assign rot_l = {op_a, op_a} << shamt;
   assign rot_r = {op_a, op_a} >> shamt;

   // one extra bit on the adder catches the unsigned carry out
   assign add_full = {1'b0, op_a} + {1'b0, op_b} + {{DATA_W{1'b0}}, req.cin};
   assign sum      = add_full[DATA_W-1:0];
   assign cout     = add_full[DATA_W];

   // signed overflow happens when both operands agree in sign and the sum does not
   assign sign_ofl = (op_a[DATA_W-1] == op_b[DATA_W-1]) &&
                     (sum[DATA_W-1] != op_a[DATA_W-1]);

   always_comb begin
      result = '0;
      case (req.alu_op)
         op_rol: result = rot_l[2*DATA_W-1:DATA_W];
         op_sll: result = op_a << shamt;        // zero fill
         op_ror: result = rot_r[DATA_W-1:0];
         op_srl: result = op_a >> shamt;        // zero fill, not arithmetic
         op_add: result = sum;
         op_or:  result = op_a | op_b;
         op_xor: result = op_a ^ op_b;
         op_and: result = op_a & op_b;
      endcase
   end

   assign is_zero = ~|result;

   // the sign bit of the sum is wrong exactly when the add overflowed
   assign is_ltz = sum[DATA_W-1] ^ sign_ofl;

   assign res.alu_out = result;
   assign res.zero    = is_zero;
   assign res.ofl     = (req.alu_op == op_add) ? (req.sign ? sign_ofl : cout) : 1'b0;
   assign res.ltz     = is_ltz;
   assign res.lteq    = is_ltz | is_zero;

endmodule

`default_nettype wire

//--- verilog/exec_branch.sv
// ==========================================================================
// Combinational branch unit. The condition looks at oprnd_1 only, and both
// targets wrap around at DATA_W bits.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module exec_branch #(
   parameter int DATA_W = exec_pkg::DATA_W_DEF
) (
   input  exec_pkg::ex_req_t req,
   output exec_pkg::br_res_t res
);
   import exec_pkg::*;

   logic              is_zero;
   logic              is_neg;
   logic              take_br;
   logic [DATA_W-1:0] pc_target;
   logic [DATA_W-1:0] reg_target;

   assign is_zero = ~|req.oprnd_1;
   assign is_neg  = req.oprnd_1[DATA_W-1];

   always_comb begin
      take_br = 1'b0;
      case (req.br_cond)
         cond_eqz: take_br = is_zero;
         cond_nez: take_br = ~is_zero;
         cond_ltz: take_br = is_neg;
         cond_gez: take_br = ~is_neg;
      endcase
   end

   // a jump always redirects, a branch only when its condition holds
   assign res.pc_src = req.jmp_instr | (req.br_instr & take_br);

   assign pc_target  = req.pc_inc + req.sext_imm;
   assign reg_target = req.pc_inc + req.oprnd_1;  // register-relative jumps

   assign res.pc_target  = pc_target;
   assign res.reg_target = reg_target;

endmodule

`default_nettype wire

//--- verilog/exec_pkg.sv
// ==========================================================================
// Shared types for the 16-bit execute stage. The struct fields are sized by
// DATA_W_DEF, so any module built with another DATA_W needs this package
// edited to match.
// ==========================================================================
`default_nettype none

package exec_pkg;

   parameter int DATA_W_DEF = 16;

   // ALU opcodes, encoded as the instruction decoder hands them over
   typedef enum logic [2:0] {
      op_rol = 3'd0,
      op_sll = 3'd1,
      op_ror = 3'd2,
      op_srl = 3'd3,
      op_add = 3'd4,
      op_or  = 3'd5,
      op_xor = 3'd6,
      op_and = 3'd7
   } alu_op_e;

   // branch conditions, all of them test the first operand against zero
   typedef enum logic [1:0] {
      cond_eqz = 2'd0,
      cond_nez = 2'd1,
      cond_ltz = 2'd2,
      cond_gez = 2'd3
   } br_cond_e;

   typedef struct packed {
      logic [DATA_W_DEF-1:0] oprnd_1;
      logic [DATA_W_DEF-1:0] oprnd_2;
      logic [DATA_W_DEF-1:0] sext_imm;  // already sign extended by decode
      logic [DATA_W_DEF-1:0] pc_inc;    // address of the next instruction
      alu_op_e               alu_op;
      logic                  inv_a;
      logic                  inv_b;
      logic                  cin;
      logic                  sign;      // selects signed overflow for add
      br_cond_e              br_cond;
      logic                  br_instr;
      logic                  jmp_instr;
   } ex_req_t;

   typedef struct packed {
      logic [DATA_W_DEF-1:0] alu_out;
      logic                  zero;
      logic                  ofl;
      logic                  ltz;
      logic                  lteq;
   } alu_res_t;

   typedef struct packed {
      logic                  pc_src;     // high when control is redirected
      logic [DATA_W_DEF-1:0] pc_target;  // next pc plus the immediate
      logic [DATA_W_DEF-1:0] reg_target; // next pc plus the first operand
   } br_res_t;

   typedef struct packed {
      logic [DATA_W_DEF-1:0] alu_out;
      logic                  zero;
      logic                  ofl;
      logic                  ltz;
      logic                  lteq;
      logic                  pc_src;
      logic [DATA_W_DEF-1:0] pc_target;
      logic [DATA_W_DEF-1:0] reg_target;
   } ex_resp_t;

endpackage

`default_nettype wire

//--- verilog/exec_result.sv
// ==========================================================================
// One-entry output register with valid/ready on both sides. in_ready
// follows out_ready combinationally, so a full register can be refilled in
// the cycle it drains and the stage keeps one packet per cycle.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module exec_result #(
   parameter int DATA_W = exec_pkg::DATA_W_DEF
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               in_valid,
   output logic               in_ready,
   input  exec_pkg::alu_res_t alu_res,
   input  exec_pkg::br_res_t  br_res,
   output logic               out_valid,
   input  logic               out_ready,
   output exec_pkg::ex_resp_t out_resp
);
   import exec_pkg::*;

   logic     full;
   logic     in_fire;
   ex_resp_t resp_d;
   ex_resp_t resp_q;

   // the response struct is sized by the package, so the width has to agree
   if (DATA_W != DATA_W_DEF) begin : g_width_check
      $error("exec_result: DATA_W differs from exec_pkg::DATA_W_DEF");
   end

   // accept when empty, or when the held result leaves in this same cycle
   assign in_ready = ~full | out_ready;
   assign in_fire  = in_valid & in_ready;

   always_comb begin
      resp_d.alu_out    = alu_res.alu_out;
      resp_d.zero       = alu_res.zero;
      resp_d.ofl        = alu_res.ofl;
      resp_d.ltz        = alu_res.ltz;
      resp_d.lteq       = alu_res.lteq;
      resp_d.pc_src     = br_res.pc_src;
      resp_d.pc_target  = br_res.pc_target;
      resp_d.reg_target = br_res.reg_target;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         full <= 1'b0;
      end else if (in_fire) begin
         full <= 1'b1;               // a new packet replaces or fills the slot
      end else if (out_ready) begin
         full <= 1'b0;
      end
   end

   // payload only moves on an input transfer, so a stalled result holds still
   always_ff @(posedge clk) begin
      if (in_fire) begin
         resp_q <= resp_d;
      end
   end

   assign out_valid = full;
   assign out_resp  = resp_q;

endmodule

`default_nettype wire

//--- verilog/exec_top.sv
// ==========================================================================
// Execute stage top. One cycle from an input transfer to out_valid, and a
// packet per cycle while out_ready stays high. DATA_W must match the
// package default.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module exec_top #(
   parameter int DATA_W = exec_pkg::DATA_W_DEF
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               in_valid,
   output logic               in_ready,
   input  exec_pkg::ex_req_t  in_req,
   output logic               out_valid,
   input  logic               out_ready,
   output exec_pkg::ex_resp_t out_resp
);
   import exec_pkg::*;

   alu_res_t alu_res;
   br_res_t  br_res;

   // both units see the request in the same cycle
   exec_alu #(
      .DATA_W (DATA_W)
   ) u_alu (
      .req (in_req),
      .res (alu_res)
   );

   exec_branch #(
      .DATA_W (DATA_W)
   ) u_branch (
      .req (in_req),
      .res (br_res)
   );

   exec_result #(
      .DATA_W (DATA_W)
   ) u_result (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .alu_res   (alu_res),
      .br_res    (br_res),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_resp  (out_resp)
   );

endmodule

`default_nettype wire
